// File: hw/vertex_arbiter_pkg.sv
// Widths, CU count and buffer depths of the vertex arbiter
// Job, read command and response structs
// Round-robin pick shared by both arbiters
package vertex_arbiter_pkg;

	////////////////////
	// Sizes
	////////////////////
	localparam int NUM_VERTEX_CU           = 4;
	localparam int CU_ID_BITS              = $clog2(NUM_VERTEX_CU);
	localparam int VERTEX_SIZE_BITS        = 32;
	localparam int EDGE_SIZE_BITS          = 32;
	localparam int ADDRESS_BITS            = 64;
	localparam int CMD_SIZE_BITS           = 8;
	localparam int RESP_TAG_BITS           = 8;
	localparam int VERTEX_JOB_BUFFER_DEPTH = 16;
	localparam int READ_CMD_BUFFER_DEPTH   = 16;
	// Free entries left when almost-full rises
	localparam int BUFFER_ALFULL_MARGIN    = 4;

	typedef logic [CU_ID_BITS-1:0]       cu_id_t;
	typedef logic [VERTEX_SIZE_BITS-1:0] vertex_count_t;
	typedef logic [EDGE_SIZE_BITS-1:0]   edge_count_t;
	typedef logic [ADDRESS_BITS-1:0]     address_t;
	typedef logic [CMD_SIZE_BITS-1:0]    cmd_size_t;
	typedef logic [RESP_TAG_BITS-1:0]    resp_tag_t;

	////////////////////
	// Bus structs
	////////////////////
	typedef struct packed {
		logic          valid;
		vertex_count_t vertex_id;
		vertex_count_t in_degree;
		vertex_count_t out_degree;
		edge_count_t   edges_idx;
	} vertex_job_t;

	// Size counted in cache lines
	typedef struct packed {
		logic      valid;
		cu_id_t    cu_id;
		address_t  address;
		cmd_size_t size;
	} read_command_t;

	typedef struct packed {
		logic      valid;
		cu_id_t    cu_id;
		resp_tag_t tag;
	} response_t;

	// First requester after last, wrapping around
	function automatic cu_id_t rr_pick(input logic [NUM_VERTEX_CU-1:0] req, input cu_id_t last);
		cu_id_t idx;
		rr_pick = last;
		for (int k = NUM_VERTEX_CU; k >= 1; k--) begin
			idx = cu_id_t'(last + k);
			if (req[idx])
				rr_pick = idx;
		end
	endfunction

endpackage

// File: hw/job_fifo.sv
// Synchronous circular FIFO with full, almost-full and empty flags
// Read data is registered on pop
`timescale 1ns/1ps

module job_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);
	import vertex_arbiter_pkg::*;

	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	// Overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and output register
	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
		if (do_pop)
			data_out <= mem[rd_ptr];
	end

	assign full   = (count == CNT_BITS'(DEPTH));
	// Rises once free entries drop to the margin
	assign alfull = (count >= CNT_BITS'(DEPTH - BUFFER_ALFULL_MARGIN));
	assign empty  = (count == '0);

endmodule

// File: hw/vertex_job_dispatch.sv
// Vertex job buffer with round-robin hand-out to requesting CUs
// Jobs leave in arrival order, one per served request
`timescale 1ns/1ps

module vertex_job_dispatch (
	input  logic                                       clock,
	input  logic                                       rstn,
	input  logic                                       enabled,
	input  vertex_arbiter_pkg::vertex_job_t            vertex_job_in,
	output logic                                       vertex_job_request,
	input  logic [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] request_vertex_job_cu,
	output vertex_arbiter_pkg::vertex_job_t [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] vertex_job_cu_out
);
	import vertex_arbiter_pkg::*;

	vertex_job_t              job_in_q;
	vertex_job_t              fifo_out;
	logic                     fifo_alfull;
	logic                     fifo_empty;
	logic                     fifo_pop;
	logic                     held;
	logic                     hand_out;
	logic [NUM_VERTEX_CU-1:0] req_q;
	logic [NUM_VERTEX_CU-1:0] req_eff;
	logic [NUM_VERTEX_CU-1:0] grant_q1;
	logic [NUM_VERTEX_CU-1:0] grant_q2;
	cu_id_t                   last_served;
	cu_id_t                   winner;

	////////////////////
	// Input side
	////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_in_q           <= '0;
			vertex_job_request <= 1'b0;
			req_q              <= '0;
		end else if (enabled) begin
			job_in_q           <= vertex_job_in;
			vertex_job_request <= !fifo_alfull;
			req_q              <= request_vertex_job_cu;
		end
	end

	job_fifo #(
		.WIDTH($bits(vertex_job_t)),
		.DEPTH(VERTEX_JOB_BUFFER_DEPTH)
	) vertex_job_buffer_i (
		.clock   (clock),
		.rstn    (rstn),
		.push    (enabled && job_in_q.valid),
		.data_in (job_in_q),
		.pop     (fifo_pop),
		.data_out(fifo_out),
		.full    (),
		.alfull  (fifo_alfull),
		.empty   (fifo_empty)
	);

	////////////////////
	// Hand-out
	////////////////////
	// A served CU still shows its request for two sampled cycles
	assign req_eff  = req_q & ~grant_q1 & ~grant_q2;
	assign fifo_pop = enabled && !held && !fifo_empty && (|req_eff);
	assign hand_out = enabled && held && (|req_eff);
	assign winner   = rr_pick(req_eff, last_served);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			held        <= 1'b0;
			grant_q1    <= '0;
			grant_q2    <= '0;
			last_served <= cu_id_t'(NUM_VERTEX_CU - 1);
		end else if (enabled) begin
			grant_q2 <= grant_q1;
			grant_q1 <= '0;
			if (fifo_pop)
				held <= 1'b1;
			if (hand_out) begin
				held             <= 1'b0;
				grant_q1[winner] <= 1'b1;
				last_served      <= winner;
			end
		end
	end

	// Popped job broadcast, only the winner sees valid
	always_comb begin
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			vertex_job_cu_out[i]       = fifo_out;
			vertex_job_cu_out[i].valid = grant_q1[i];
		end
	end

endmodule

// File: hw/read_command_arbiter.sv
// Round-robin read command arbitration over the vertex CUs
// Burst buffer drained onto the memory command bus by request/grant
`timescale 1ns/1ps

module read_command_arbiter (
	input  logic                                         clock,
	input  logic                                         rstn,
	input  logic                                         enabled,
	input  vertex_arbiter_pkg::read_command_t [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] read_command_cu,
	input  logic [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] request_read_command_cu,
	output logic [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] ready_read_command_cu,
	output vertex_arbiter_pkg::read_command_t            read_command_out,
	output logic                                         read_command_bus_request,
	input  logic                                         read_command_bus_grant,
	input  logic                                         read_buffer_alfull
);
	import vertex_arbiter_pkg::*;

	read_command_t [NUM_VERTEX_CU-1:0] cmd_q;
	read_command_t                     pick_q;
	read_command_t                     push_q;
	read_command_t                     fifo_out;
	logic [NUM_VERTEX_CU-1:0]          submit_q;
	logic [NUM_VERTEX_CU-1:0]          ready_q2;
	logic [NUM_VERTEX_CU-1:0]          eligible;
	cu_id_t                            last_served;
	cu_id_t                            winner;
	logic                              take;
	logic                              pick_valid;
	logic                              push_valid;
	logic                              fifo_alfull;
	logic                              fifo_empty;
	logic                              grant_q;
	logic                              mem_alfull_q;
	logic                              bus_pop;
	logic                              out_valid_q;

	////////////////////
	// CU side
	////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			submit_q <= '0;
		end else if (enabled) begin
			for (int i = 0; i < NUM_VERTEX_CU; i++)
				submit_q[i] <= request_read_command_cu[i] && read_command_cu[i].valid;
		end
	end

	// Mask a CU until its dropped request is sampled
	assign eligible = submit_q & ~ready_read_command_cu & ~ready_q2;
	assign take     = enabled && (|eligible) && !fifo_alfull;
	assign winner   = rr_pick(eligible, last_served);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ready_read_command_cu <= '0;
			ready_q2              <= '0;
			last_served           <= cu_id_t'(NUM_VERTEX_CU - 1);
			pick_valid            <= 1'b0;
			push_valid            <= 1'b0;
		end else if (enabled) begin
			ready_q2              <= ready_read_command_cu;
			ready_read_command_cu <= '0;
			pick_valid            <= take;
			push_valid            <= pick_valid;
			if (take) begin
				ready_read_command_cu[winner] <= 1'b1;
				last_served                   <= winner;
			end
		end
	end

	// Picked command, two stages into the burst buffer
	always_ff @(posedge clock) begin
		if (enabled) begin
			cmd_q  <= read_command_cu;
			pick_q <= cmd_q[winner];
			push_q <= pick_q;
		end
	end

	job_fifo #(
		.WIDTH($bits(read_command_t)),
		.DEPTH(READ_CMD_BUFFER_DEPTH)
	) burst_read_command_buffer_i (
		.clock   (clock),
		.rstn    (rstn),
		.push    (enabled && push_valid),
		.data_in (push_q),
		.pop     (bus_pop),
		.data_out(fifo_out),
		.full    (),
		.alfull  (fifo_alfull),
		.empty   (fifo_empty)
	);

	////////////////////
	// Memory bus side
	////////////////////
	// Grants count only while memory side has room
	assign bus_pop = enabled && grant_q && !mem_alfull_q && !fifo_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_q                  <= 1'b0;
			mem_alfull_q             <= 1'b0;
			read_command_bus_request <= 1'b0;
			out_valid_q              <= 1'b0;
		end else if (enabled) begin
			grant_q                  <= read_command_bus_grant;
			mem_alfull_q             <= read_buffer_alfull;
			read_command_bus_request <= !fifo_empty && !read_buffer_alfull;
			out_valid_q              <= bus_pop;
		end
	end

	always_comb begin
		read_command_out       = fifo_out;
		read_command_out.valid = out_valid_q;
	end

endmodule

// File: hw/response_router.sv
// Routes read and write responses to the CU named by their cu_id
// Payload goes to every entry, the valid bit picks the CU
`timescale 1ns/1ps

module response_router (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  vertex_arbiter_pkg::response_t read_response_in,
	input  vertex_arbiter_pkg::response_t write_response_in,
	output vertex_arbiter_pkg::response_t [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] read_response_cu_out,
	output vertex_arbiter_pkg::response_t [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] write_response_cu_out
);
	import vertex_arbiter_pkg::*;

	// Channel 0 is reads, channel 1 writes
	response_t [1:0]               resp_in;
	response_t [1:0]               resp_q;
	response_t [1:0]               resp_out_q;
	logic [1:0]                    in_valid_q;
	logic [1:0][NUM_VERTEX_CU-1:0] sel_q;

	assign resp_in[0] = read_response_in;
	assign resp_in[1] = write_response_in;

	// Capture, then decode cu_id to a one-hot valid
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_valid_q <= '0;
			sel_q      <= '0;
		end else if (enabled) begin
			for (int c = 0; c < 2; c++) begin
				in_valid_q[c] <= resp_in[c].valid;
				sel_q[c]      <= '0;
				if (in_valid_q[c])
					sel_q[c][resp_q[c].cu_id] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enabled) begin
			resp_q     <= resp_in;
			resp_out_q <= resp_q;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			read_response_cu_out[i]        = resp_out_q[0];
			read_response_cu_out[i].valid  = sel_q[0][i];
			write_response_cu_out[i]       = resp_out_q[1];
			write_response_cu_out[i].valid = sel_q[1][i];
		end
	end

endmodule

// File: hw/done_counter_reduce.sv
// Sums per-CU processed vertex and edge counters into two totals
// Totals wrap at the counter width
`timescale 1ns/1ps

module done_counter_reduce (
	input  logic                            clock,
	input  logic                            rstn,
	input  vertex_arbiter_pkg::vertex_count_t [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] vertex_num_counter_cu,
	input  vertex_arbiter_pkg::edge_count_t [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] edge_num_counter_cu,
	output vertex_arbiter_pkg::vertex_count_t vertex_job_counter_done,
	output vertex_arbiter_pkg::edge_count_t   edge_job_counter_done
);
	import vertex_arbiter_pkg::*;

	vertex_count_t [NUM_VERTEX_CU-1:0] vertex_q;
	edge_count_t [NUM_VERTEX_CU-1:0]   edge_q;
	vertex_count_t                     vertex_sum;
	edge_count_t                       edge_sum;

	// Sampled every cycle, independent of enabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_q                <= '0;
			edge_q                  <= '0;
			vertex_job_counter_done <= '0;
			edge_job_counter_done   <= '0;
		end else begin
			vertex_q                <= vertex_num_counter_cu;
			edge_q                  <= edge_num_counter_cu;
			vertex_job_counter_done <= vertex_sum;
			edge_job_counter_done   <= edge_sum;
		end
	end

	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			vertex_sum = vertex_sum + vertex_q[i];
			edge_sum   = edge_sum + edge_q[i];
		end
	end

endmodule

// File: hw/vertex_arbiter_control.sv
// Top of the vertex-side arbiter
// Job dispatch, read command arbiter, response router and counter sums
`timescale 1ns/1ps

module vertex_arbiter_control (
	input  logic                                         clock,
	input  logic                                         rstn,
	input  logic                                         enabled,
	input  vertex_arbiter_pkg::vertex_job_t              vertex_job_in,
	output logic                                         vertex_job_request,
	input  logic [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] request_vertex_job_cu,
	output vertex_arbiter_pkg::vertex_job_t [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] vertex_job_cu_out,
	input  vertex_arbiter_pkg::read_command_t [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] read_command_cu,
	input  logic [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] request_read_command_cu,
	output logic [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] ready_read_command_cu,
	output vertex_arbiter_pkg::read_command_t            read_command_out,
	output logic                                         read_command_bus_request,
	input  logic                                         read_command_bus_grant,
	input  logic                                         read_buffer_alfull,
	input  vertex_arbiter_pkg::response_t                read_response_in,
	input  vertex_arbiter_pkg::response_t                write_response_in,
	output vertex_arbiter_pkg::response_t [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] read_response_cu_out,
	output vertex_arbiter_pkg::response_t [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] write_response_cu_out,
	input  vertex_arbiter_pkg::vertex_count_t [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] vertex_num_counter_cu,
	input  vertex_arbiter_pkg::edge_count_t [vertex_arbiter_pkg::NUM_VERTEX_CU-1:0] edge_num_counter_cu,
	output vertex_arbiter_pkg::vertex_count_t            vertex_job_counter_done,
	output vertex_arbiter_pkg::edge_count_t              edge_job_counter_done
);

	vertex_job_dispatch vertex_job_dispatch_i (
		.clock                (clock),
		.rstn                 (rstn),
		.enabled              (enabled),
		.vertex_job_in        (vertex_job_in),
		.vertex_job_request   (vertex_job_request),
		.request_vertex_job_cu(request_vertex_job_cu),
		.vertex_job_cu_out    (vertex_job_cu_out)
	);

	read_command_arbiter read_command_arbiter_i (
		.clock                   (clock),
		.rstn                    (rstn),
		.enabled                 (enabled),
		.read_command_cu         (read_command_cu),
		.request_read_command_cu (request_read_command_cu),
		.ready_read_command_cu   (ready_read_command_cu),
		.read_command_out        (read_command_out),
		.read_command_bus_request(read_command_bus_request),
		.read_command_bus_grant  (read_command_bus_grant),
		.read_buffer_alfull      (read_buffer_alfull)
	);

	response_router response_router_i (
		.clock                (clock),
		.rstn                 (rstn),
		.enabled              (enabled),
		.read_response_in     (read_response_in),
		.write_response_in    (write_response_in),
		.read_response_cu_out (read_response_cu_out),
		.write_response_cu_out(write_response_cu_out)
	);

	done_counter_reduce done_counter_reduce_i (
		.clock                  (clock),
		.rstn                   (rstn),
		.vertex_num_counter_cu  (vertex_num_counter_cu),
		.edge_num_counter_cu    (edge_num_counter_cu),
		.vertex_job_counter_done(vertex_job_counter_done),
		.edge_job_counter_done  (edge_job_counter_done)
	);

endmodule

// File: dv/vertex_arbiter_model.svh
// Reference functions for the vertex arbiter testbench
// Response routing, wrapped counter sums and round-robin order
`ifndef VERTEX_ARBITER_MODEL_SVH
`define VERTEX_ARBITER_MODEL_SVH

// One-hot of the CU that should see this response
function automatic logic [NUM_VERTEX_CU-1:0] route_onehot(input response_t resp);
	logic [NUM_VERTEX_CU-1:0] sel;
	sel = '0;
	if (resp.valid)
		sel[resp.cu_id] = 1'b1;
	return sel;
endfunction

// Sum of all per-CU counts, wrapping at the counter width
function automatic logic [VERTEX_SIZE_BITS-1:0] wrapped_sum(
	input logic [NUM_VERTEX_CU-1:0][VERTEX_SIZE_BITS-1:0] counts
);
	logic [VERTEX_SIZE_BITS-1:0] total;
	total = '0;
	for (int i = 0; i < NUM_VERTEX_CU; i++)
		total = total + counts[i];
	return total;
endfunction

// Scan upward from the CU after last, wrapping around
// Keeps last when nobody requests
function automatic cu_id_t next_rr(input logic [NUM_VERTEX_CU-1:0] req, input cu_id_t last);
	int     idx;
	cu_id_t pick;
	pick = last;
	for (int k = 1; k <= NUM_VERTEX_CU; k++) begin
		idx = (int'(last) + k) % NUM_VERTEX_CU;
		if (req[idx]) begin
			pick = cu_id_t'(idx);
			break;
		end
	end
	return pick;
endfunction

`endif

// File: dv/vertex_arbiter_tb.sv
// Testbench for the vertex arbiter top level
// Clock, reset, stimulus, comparison process, timeout and report
`timescale 1ns/1ps

module vertex_arbiter_tb;
	import vertex_arbiter_pkg::*;
	`include "vertex_arbiter_model.svh"

	localparam int READ_CMDS_PER_CU = 8;
	localparam int BP_CMDS_PER_CU   = 6;
	localparam int NUM_JOBS         = 40;
	// Rough cycle budget of every test added up
	localparam int TEST_CYCLES      = 10 + 60 + 100 + 300 + 300 + 480;
	localparam int CYCLE_LIMIT      = 4 * TEST_CYCLES;

	logic                                clock;
	logic                                rstn;
	logic                                enabled;
	vertex_job_t                         vertex_job_in;
	logic                                vertex_job_request;
	logic [NUM_VERTEX_CU-1:0]            request_vertex_job_cu;
	vertex_job_t [NUM_VERTEX_CU-1:0]     vertex_job_cu_out;
	read_command_t [NUM_VERTEX_CU-1:0]   read_command_cu;
	logic [NUM_VERTEX_CU-1:0]            request_read_command_cu;
	logic [NUM_VERTEX_CU-1:0]            ready_read_command_cu;
	read_command_t                       read_command_out;
	logic                                read_command_bus_request;
	logic                                read_command_bus_grant;
	logic                                read_buffer_alfull;
	response_t                           read_response_in;
	response_t                           write_response_in;
	response_t [NUM_VERTEX_CU-1:0]       read_response_cu_out;
	response_t [NUM_VERTEX_CU-1:0]       write_response_cu_out;
	vertex_count_t [NUM_VERTEX_CU-1:0]   vertex_num_counter_cu;
	edge_count_t [NUM_VERTEX_CU-1:0]     edge_num_counter_cu;
	vertex_count_t                       vertex_job_counter_done;
	edge_count_t                         edge_job_counter_done;

	integer        seed;
	logic [31:0]   pattern [1024];
	int            drive_cycle;
	int            cycles;
	int            errors;
	int            checks;
	int            cmds_out;
	int            jobs_out;
	int            ready_pulses;
	logic          grant_en;
	logic          dispatch_en;
	logic          bp_check;
	read_command_t cmd_src [NUM_VERTEX_CU][$];
	read_command_t exp_cmd [NUM_VERTEX_CU][$];
	vertex_job_t   job_src [$];
	vertex_job_t   exp_job [$];

	// Input history, d2 is what the DUT sampled two edges back
	response_t                         rd_d1, rd_d2, wr_d1, wr_d2;
	vertex_count_t [NUM_VERTEX_CU-1:0] vcnt_d1, vcnt_d2;
	edge_count_t [NUM_VERTEX_CU-1:0]   ecnt_d1, ecnt_d2;
	logic [NUM_VERTEX_CU-1:0]          rreq_d1, rreq_d2, rpulse_d1, rpulse_d2;
	logic [NUM_VERTEX_CU-1:0]          vreq_d1, vreq_d2, vpulse_d1, vpulse_d2;
	cu_id_t                            rlast, vlast;

	vertex_arbiter_control vertex_arbiter_control_i (.*);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, outputs stopped arriving", cycles);
			$display("test failed");
			$finish;
		end
	end

	////////////////////
	// CU and memory side drivers
	////////////////////
	always @(posedge clock) begin
		logic [31:0] pat;
		if (rstn) begin
			pat = pattern[drive_cycle % 1024];
			drive_cycle++;
			read_command_bus_grant <= grant_en && pat[0];
			for (int i = 0; i < NUM_VERTEX_CU; i++) begin
				// A ready pulse means the front command was taken
				if (ready_read_command_cu[i] && cmd_src[i].size() > 0)
					void'(cmd_src[i].pop_front());
				if (cmd_src[i].size() > 0) begin
					read_command_cu[i]         <= cmd_src[i][0];
					request_read_command_cu[i] <= 1'b1;
				end else begin
					read_command_cu[i]         <= '0;
					request_read_command_cu[i] <= 1'b0;
				end
				if (vertex_job_cu_out[i].valid)
					request_vertex_job_cu[i] <= 1'b0;
				else if (dispatch_en && pat[i+1])
					request_vertex_job_cu[i] <= 1'b1;
			end
			if (vertex_job_request && job_src.size() > 0)
				vertex_job_in <= job_src.pop_front();
			else
				vertex_job_in <= '0;
		end
	end

	task automatic check_routing(input string name, input response_t [NUM_VERTEX_CU-1:0] outs,
		input response_t sent);
		logic [NUM_VERTEX_CU-1:0] got;
		logic [NUM_VERTEX_CU-1:0] want;
		for (int i = 0; i < NUM_VERTEX_CU; i++)
			got[i] = outs[i].valid;
		want = route_onehot(sent);
		checks++;
		assert (got == want) else begin
			$display("** Error %s valid: got %h expected %h", name, got, want);
			errors++;
		end
		if (sent.valid) begin
			checks++;
			assert (outs[sent.cu_id].tag == sent.tag) else begin
				$display("** Error %s tag: got %h expected %h", name, outs[sent.cu_id].tag,
					sent.tag);
				errors++;
			end
		end
	endtask

	////////////////////
	// Comparison process
	////////////////////
	always @(negedge clock) begin
		logic [NUM_VERTEX_CU-1:0] rreq_now;
		logic [NUM_VERTEX_CU-1:0] vpulse_now;
		logic [NUM_VERTEX_CU-1:0] want;
		vertex_count_t            vsum;
		edge_count_t              esum;
		read_command_t            cmd_front;
		cu_id_t                   w;
		if (!rstn) begin
			{rd_d1, rd_d2, wr_d1, wr_d2} = '0;
			{vcnt_d1, vcnt_d2, ecnt_d1, ecnt_d2} = '0;
			{rreq_d1, rreq_d2, rpulse_d1, rpulse_d2} = '0;
			{vreq_d1, vreq_d2, vpulse_d1, vpulse_d2} = '0;
			rlast = cu_id_t'(NUM_VERTEX_CU - 1);
			vlast = cu_id_t'(NUM_VERTEX_CU - 1);
		end else begin
			check_routing("read_response_cu_out", read_response_cu_out, rd_d2);
			check_routing("write_response_cu_out", write_response_cu_out, wr_d2);
			vsum = wrapped_sum(vcnt_d2);
			esum = wrapped_sum(ecnt_d2);
			checks++;
			assert (vertex_job_counter_done == vsum) else begin
				$display("** Error vertex_job_counter_done: got %h expected %h",
					vertex_job_counter_done, vsum);
				errors++;
			end
			checks++;
			assert (edge_job_counter_done == esum) else begin
				$display("** Error edge_job_counter_done: got %h expected %h",
					edge_job_counter_done, esum);
				errors++;
			end

			if (read_command_out.valid) begin
				checks++;
				cmds_out++;
				assert (exp_cmd[read_command_out.cu_id].size() > 0) else begin
					$display("Read command for CU %0d left the bus with none pending",
						read_command_out.cu_id);
					errors++;
				end
				if (exp_cmd[read_command_out.cu_id].size() > 0) begin
					cmd_front = exp_cmd[read_command_out.cu_id].pop_front();
					assert (read_command_out == cmd_front) else begin
						$display("** Error read_command_out: got %h expected %h",
							read_command_out, cmd_front);
						errors++;
					end
				end
			end

			// Ready pulse against the requests the arbiter last sampled
			if (ready_read_command_cu != '0) begin
				w = next_rr(rreq_d2 & ~rpulse_d1 & ~rpulse_d2, rlast);
				want = '0;
				want[w] = 1'b1;
				checks++;
				assert (ready_read_command_cu == want) else begin
					$display("** Error ready_read_command_cu: got %h expected %h",
						ready_read_command_cu, want);
					errors++;
				end
				rlast = w;
				ready_pulses++;
			end

			if (bp_check) begin
				checks++;
				assert (!read_command_bus_request && !read_command_out.valid) else begin
					$display("Memory bus active while read_buffer_alfull was high");
					errors++;
				end
			end

			for (int i = 0; i < NUM_VERTEX_CU; i++)
				vpulse_now[i] = vertex_job_cu_out[i].valid;
			if (vpulse_now != '0) begin
				w = next_rr(vreq_d2 & ~vpulse_d1 & ~vpulse_d2, vlast);
				want = '0;
				want[w] = 1'b1;
				checks++;
				assert (vpulse_now == want && (vreq_d2 & want) != '0) else begin
					$display("** Error vertex_job_cu_out valid: got %h expected %h",
						vpulse_now, want);
					errors++;
				end
				vlast = w;
				jobs_out++;
				assert (exp_job.size() > 0) else begin
					$display("Vertex job delivered with none pushed");
					errors++;
				end
				if (exp_job.size() > 0) begin
					assert (vertex_job_cu_out[w] == exp_job[0]) else begin
						$display("** Error vertex_job_cu_out: got %h expected %h",
							vertex_job_cu_out[w], exp_job[0]);
						errors++;
					end
					void'(exp_job.pop_front());
				end
			end

			for (int i = 0; i < NUM_VERTEX_CU; i++)
				rreq_now[i] = request_read_command_cu[i] && read_command_cu[i].valid;
			rd_d2 = rd_d1;
			rd_d1 = read_response_in;
			wr_d2 = wr_d1;
			wr_d1 = write_response_in;
			vcnt_d2 = vcnt_d1;
			vcnt_d1 = vertex_num_counter_cu;
			ecnt_d2 = ecnt_d1;
			ecnt_d1 = edge_num_counter_cu;
			rreq_d2 = rreq_d1;
			rreq_d1 = rreq_now;
			rpulse_d2 = rpulse_d1;
			rpulse_d1 = ready_read_command_cu;
			vreq_d2 = vreq_d1;
			vreq_d1 = request_vertex_job_cu;
			vpulse_d2 = vpulse_d1;
			vpulse_d1 = vpulse_now;
		end
	end

	task automatic print_result(input string name, input int errs_before);
		$display("%s: %0d errors", name, errors - errs_before);
	endtask

	task automatic load_read_commands(input int per_cu);
		read_command_t c;
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			for (int k = 0; k < per_cu; k++) begin
				c.valid   = 1'b1;
				c.cu_id   = cu_id_t'(i);
				c.address = {$random(seed), $random(seed)};
				c.size    = cmd_size_t'($random(seed));
				cmd_src[i].push_back(c);
				exp_cmd[i].push_back(c);
			end
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////
	initial begin
		logic                     any_valid;
		logic [31:0]              rnd;
		vertex_job_t              job;
		int                       mark;
		int                       target;
		int                       pending;
		seed = 32'he5be6705;
		for (int k = 0; k < 1024; k++)
			pattern[k] = $random(seed);
		{drive_cycle, cycles, errors, checks, cmds_out, jobs_out, ready_pulses} = '0;
		{grant_en, dispatch_en, bp_check} = '0;
		rstn = 1'b0;
		enabled = 1'b1;
		vertex_job_in = '0;
		request_vertex_job_cu = '0;
		read_command_cu = '0;
		request_read_command_cu = '0;
		read_command_bus_grant = 1'b0;
		read_buffer_alfull = 1'b0;
		read_response_in = '0;
		write_response_in = '0;
		vertex_num_counter_cu = '0;
		edge_num_counter_cu = '0;

		// Reset state, checked in the last reset cycle
		repeat (4) @(posedge clock);
		@(negedge clock);
		mark = errors;
		any_valid = 1'b0;
		for (int i = 0; i < NUM_VERTEX_CU; i++)
			any_valid = any_valid | vertex_job_cu_out[i].valid | read_response_cu_out[i].valid |
				write_response_cu_out[i].valid;
		checks++;
		assert (!any_valid && !vertex_job_request && ready_read_command_cu == '0 &&
			!read_command_bus_request && !read_command_out.valid &&
			vertex_job_counter_done == '0 && edge_job_counter_done == '0) else begin
			$display("Outputs not idle during reset");
			errors++;
		end
		@(posedge clock);
		rstn <= 1'b1;
		print_result("reset state", mark);

		mark = errors;
		repeat (40) begin
			@(posedge clock);
			rnd = $random(seed);
			read_response_in  <= {rnd[0], cu_id_t'(rnd[3:2]), resp_tag_t'(rnd[15:8])};
			write_response_in <= {rnd[1], cu_id_t'(rnd[5:4]), resp_tag_t'(rnd[23:16])};
		end
		@(posedge clock);
		read_response_in  <= '0;
		write_response_in <= '0;
		repeat (4) @(posedge clock);
		print_result("response routing", mark);

		mark = errors;
		repeat (20) begin
			@(posedge clock);
			for (int i = 0; i < NUM_VERTEX_CU; i++) begin
				vertex_num_counter_cu[i] <= $random(seed);
				edge_num_counter_cu[i]   <= $random(seed);
			end
			repeat (3) @(posedge clock);
		end
		repeat (3) @(posedge clock);
		print_result("counter sums", mark);

		mark = errors;
		@(negedge clock);
		target = cmds_out + NUM_VERTEX_CU * READ_CMDS_PER_CU;
		load_read_commands(READ_CMDS_PER_CU);
		grant_en = 1'b1;
		while (cmds_out < target)
			@(posedge clock);
		repeat (5) @(posedge clock);
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			checks++;
			assert (exp_cmd[i].size() == 0) else begin
				$display("CU %0d has read commands that never reached the bus", i);
				errors++;
			end
		end
		print_result("read command arbitration", mark);

		mark = errors;
		@(posedge clock);
		read_buffer_alfull <= 1'b1;
		repeat (3) @(posedge clock);
		@(negedge clock);
		bp_check = 1'b1;
		target = cmds_out + NUM_VERTEX_CU * BP_CMDS_PER_CU;
		load_read_commands(BP_CMDS_PER_CU);
		repeat (40) @(posedge clock);
		pending = ready_pulses;
		repeat (20) @(posedge clock);
		checks++;
		assert (ready_pulses == pending && cmd_src[0].size() + cmd_src[1].size() +
			cmd_src[2].size() + cmd_src[3].size() > 0) else begin
			$display("Ready pulses kept coming with the burst buffer almost full");
			errors++;
		end
		@(negedge clock);
		bp_check = 1'b0;
		@(posedge clock);
		read_buffer_alfull <= 1'b0;
		while (cmds_out < target)
			@(posedge clock);
		grant_en = 1'b0;
		print_result("back-pressure", mark);

		mark = errors;
		@(negedge clock);
		target = jobs_out + NUM_JOBS;
		for (int k = 0; k < NUM_JOBS; k++) begin
			job.valid      = 1'b1;
			job.vertex_id  = $random(seed);
			job.in_degree  = $random(seed);
			job.out_degree = $random(seed);
			job.edges_idx  = $random(seed);
			job_src.push_back(job);
			exp_job.push_back(job);
		end
		dispatch_en = 1'b1;
		while (jobs_out < target)
			@(posedge clock);
		dispatch_en = 1'b0;
		repeat (5) @(posedge clock);
		checks++;
		assert (exp_job.size() == 0) else begin
			$display("Vertex jobs left undelivered");
			errors++;
		end
		print_result("vertex dispatch", mark);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: files.f
+incdir+dv
hw/vertex_arbiter_pkg.sv
hw/job_fifo.sv
hw/vertex_job_dispatch.sv
hw/read_command_arbiter.sv
hw/response_router.sv
hw/done_counter_reduce.sv
hw/vertex_arbiter_control.sv
dv/vertex_arbiter_tb.sv

// File: Bender.yml
package:
  name: vertex_arbiter

sources:
  - files:
      - hw/vertex_arbiter_pkg.sv
      - hw/job_fifo.sv
      - hw/vertex_job_dispatch.sv
      - hw/read_command_arbiter.sv
      - hw/response_router.sv
      - hw/done_counter_reduce.sv
      - hw/vertex_arbiter_control.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/vertex_arbiter_tb.sv
